//--- src.f
+incdir+include
hdl/efpga_bridge_pkg.sv
hdl/control_word_filter.sv
hdl/event_pulse_gen.sv
hdl/lint_slave_gate.sv
hdl/tcdm_port_gate.sv
hdl/efpga_bridge.sv
testbench/tb_efpga_bridge.sv

//--- Bender.yml
package:
  name: efpga_bridge

sources:
  - files:
      - hdl/efpga_bridge_pkg.sv
      - hdl/control_word_filter.sv
      - hdl/event_pulse_gen.sv
      - hdl/lint_slave_gate.sv
      - hdl/tcdm_port_gate.sv
      - hdl/efpga_bridge.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_efpga_bridge.sv

//--- include/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef enum logic [1:0] {
   VEC_CONTROL = 2'd0,  // stim is the control word
   VEC_EVENT   = 2'd1,  // stim[15:0] are event levels
   VEC_LINT    = 2'd2,  // stim[0] is wen
   VEC_TCDM    = 2'd3   // stim[4] is wen, stim[1:0] the port
} vec_kind_e;

typedef struct packed {
   vec_kind_e   kind;
   logic [3:0]  enable;   // bit 0 for events and lint, one bit per port for tcdm
   logic [31:0] stim;
   logic [7:0]  hold;     // cycles the stimulus is applied
   logic [31:0] exp_val;  // see below per kind
} tb_vector_t;

// control: control_o after the hold has settled
// event: bits that must pulse exactly once
// lint: request cycle in which lint_gnt_o rises
// tcdm: bit 0 request reaches the SoC, bit 1 read valid reaches the fabric
localparam int N_VECTORS = 14;

localparam tb_vector_t VECTORS [N_VECTORS] = '{
   '{VEC_CONTROL, 4'h0, 32'hA5A5_0001, 8'd6, 32'hA5A5_0001},
   '{VEC_CONTROL, 4'h0, 32'h1234_5678, 8'd2, 32'hA5A5_0001},
   '{VEC_CONTROL, 4'h0, 32'hDEAD_BEEF, 8'd1, 32'hA5A5_0001},
   '{VEC_CONTROL, 4'h0, 32'h0F0F_F0F0, 8'd4, 32'h0F0F_F0F0},
   '{VEC_EVENT,   4'h1, 32'h0000_0005, 8'd4, 32'h0000_0005},
   '{VEC_EVENT,   4'h0, 32'h0000_00F0, 8'd4, 32'h0000_0000},
   '{VEC_EVENT,   4'h1, 32'h0000_8001, 8'd8, 32'h0000_8001},
   '{VEC_LINT,    4'h1, 32'h0000_0001, 8'd8, 32'd5},
   '{VEC_LINT,    4'h1, 32'h0000_0000, 8'd8, 32'd5},
   '{VEC_LINT,    4'h0, 32'h0000_0001, 8'd8, 32'd1},
   '{VEC_TCDM,    4'hF, 32'h0000_0010, 8'd3, 32'd3},
   '{VEC_TCDM,    4'hF, 32'h0000_0001, 8'd3, 32'd1},
   '{VEC_TCDM,    4'hB, 32'h0000_0012, 8'd3, 32'd0},
   '{VEC_TCDM,    4'hF, 32'h0000_0013, 8'd3, 32'd3}
};

`endif

//--- testbench/tb_efpga_bridge.sv
`timescale 1ns/1ps

module tb_efpga_bridge;
   import efpga_bridge_pkg::*;

   `include "tb_vectors.svh"

   localparam int    CLK_PERIOD   = 10;
   localparam int    RESET_CYCLES = 16;
   localparam int    LIMIT_CYCLES = N_VECTORS * 20 + RESET_CYCLES;
   localparam data_t RDATA_XOR    = 32'h5A5A_C3C3;  // SoC memory read pattern
   localparam logic [11:0] L2_WINDOW_HI = 12'h1C0;  // upper bits of the L2 window

   logic                         asic_clk_i;
   logic                         rst_n;
   ctrl_word_t                   control_i;
   ctrl_word_t                   control_o;
   logic                         enable_events_i;
   logic [N_EVENTS-1:0]          events_i;
   logic [N_EVENTS-1:0]          event_o;
   logic                         enable_lint_i;
   logic                         lint_req_i;
   logic                         lint_wen_i;
   fab_addr_t                    lint_addr_i;
   data_t                        lint_wdata_i;
   be_t                          lint_be_i;
   logic                         lint_gnt_o;
   logic                         lint_rvalid_o;
   data_t                        lint_rdata_o;
   logic                         fab_lint_req_o;
   logic                         fab_lint_wen_o;
   fab_addr_t                    fab_lint_addr_o;
   data_t                        fab_lint_wdata_o;
   be_t                          fab_lint_be_o;
   logic                         fab_lint_gnt_i;
   logic                         fab_lint_rvalid_i;
   data_t                        fab_lint_rdata_i;
   logic [N_TCDM_PORTS-1:0]      enable_tcdm_i;
   logic [N_TCDM_PORTS-1:0]      fab_tcdm_req_i;
   logic [N_TCDM_PORTS-1:0]      fab_tcdm_wen_i;
   fab_addr_t [N_TCDM_PORTS-1:0] fab_tcdm_addr_i;
   data_t [N_TCDM_PORTS-1:0]     fab_tcdm_wdata_i;
   be_t [N_TCDM_PORTS-1:0]       fab_tcdm_be_i;
   logic [N_TCDM_PORTS-1:0]      fab_tcdm_gnt_o;
   logic [N_TCDM_PORTS-1:0]      fab_tcdm_rvalid_o;
   data_t [N_TCDM_PORTS-1:0]     fab_tcdm_rdata_o;
   logic [N_TCDM_PORTS-1:0]      soc_tcdm_req_o;
   logic [N_TCDM_PORTS-1:0]      soc_tcdm_wen_o;
   soc_addr_t [N_TCDM_PORTS-1:0] soc_tcdm_addr_o;
   data_t [N_TCDM_PORTS-1:0]     soc_tcdm_wdata_o;
   be_t [N_TCDM_PORTS-1:0]       soc_tcdm_be_o;
   logic [N_TCDM_PORTS-1:0]      soc_tcdm_gnt_i;
   logic [N_TCDM_PORTS-1:0]      soc_tcdm_rvalid_i;
   data_t [N_TCDM_PORTS-1:0]     soc_tcdm_rdata_i;

   int          errors     = 0;
   logic [31:0] lfsr_state = 32'hfd31fdf3;
   ctrl_word_t  ctrl_prev  = '0;  // last word that passed the filter

   efpga_bridge UUT (.*);

   initial begin
      asic_clk_i = 1'b0;
      forever #(CLK_PERIOD/2) asic_clk_i = ~asic_clk_i;
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function logic [31:0] take_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   function automatic data_t lint_read_data(input fab_addr_t a);
      return {{(DATA_W-FAB_ADDR_W){1'b0}}, ~a};
   endfunction

   function automatic data_t tcdm_read_data(input soc_addr_t a);
      return a ^ RDATA_XOR;
   endfunction

   function void report_mismatch(input string msg);
      errors++;
      $display("** Error at %0t: %s", $time, msg);
   endfunction

   task automatic next_cycle();
      @(posedge asic_clk_i);
      #1;
   endtask

   // fabric lint slave and SoC memory, each answers one cycle after a request
   initial begin : responders
      logic                    lint_seen;
      fab_addr_t               lint_addr_seen;
      logic [N_TCDM_PORTS-1:0] tcdm_seen;
      soc_addr_t               tcdm_addr_seen [N_TCDM_PORTS];
      fab_lint_gnt_i    = 1'b1;
      fab_lint_rvalid_i = 1'b0;
      fab_lint_rdata_i  = '0;
      soc_tcdm_gnt_i    = '1;
      soc_tcdm_rvalid_i = '0;
      soc_tcdm_rdata_i  = '0;
      forever begin
         @(negedge asic_clk_i);  // requests settled mid cycle
         lint_seen      = fab_lint_req_o & fab_lint_gnt_i;
         lint_addr_seen = fab_lint_addr_o;
         tcdm_seen      = soc_tcdm_req_o & soc_tcdm_gnt_i;
         for (int p = 0; p < N_TCDM_PORTS; p++) begin
            tcdm_addr_seen[p] = soc_tcdm_addr_o[p];
         end
         @(posedge asic_clk_i);
         #1;
         fab_lint_rvalid_i = lint_seen;
         fab_lint_rdata_i  = lint_seen ? lint_read_data(lint_addr_seen) : '0;
         soc_tcdm_rvalid_i = tcdm_seen;
         for (int p = 0; p < N_TCDM_PORTS; p++) begin
            soc_tcdm_rdata_i[p] = tcdm_seen[p] ? tcdm_read_data(tcdm_addr_seen[p]) : '0;
         end
      end
   end

   task automatic apply_control(input tb_vector_t v);
      ctrl_word_t want;
      control_i = v.stim;
      for (int i = 0; i < v.hold; i++) begin
         next_cycle();
         want = (i >= STABLE_SAMPLES) ? v.exp_val : ctrl_prev;  // load after third equal sample
         if (control_o !== want) begin
            report_mismatch($sformatf("control_o %h, expected %h at sample %0d",
                                      control_o, want, i));
         end
      end
      ctrl_prev = v.exp_val;
   endtask

   task automatic apply_event(input tb_vector_t v);
      int                  pulses [N_EVENTS];
      logic [N_EVENTS-1:0] want;
      logic [N_EVENTS-1:0] want_now;
      want = v.exp_val[N_EVENTS-1:0];
      for (int b = 0; b < N_EVENTS; b++) begin
         pulses[b] = 0;
      end
      enable_events_i = v.enable[0];
      events_i        = v.stim[N_EVENTS-1:0];
      for (int i = 0; i < v.hold + 3; i++) begin
         if (i == v.hold) begin
            events_i = '0;  // drop levels, tail drains
         end
         next_cycle();
         want_now = (i == 1) ? want : '0;  // pulse one cycle after the second edge
         if (event_o !== want_now) begin
            report_mismatch($sformatf("event_o %h, expected %h at cycle %0d",
                                      event_o, want_now, i));
         end
         for (int b = 0; b < N_EVENTS; b++) begin
            pulses[b] += event_o[b];
         end
      end
      for (int b = 0; b < N_EVENTS; b++) begin
         if (pulses[b] != int'(want[b])) begin
            report_mismatch($sformatf("event bit %0d gave %0d pulses, expected %0d",
                                      b, pulses[b], want[b]));
         end
      end
   endtask

   task automatic apply_lint(input tb_vector_t v);
      fab_addr_t addr;
      data_t     wdata;
      be_t       be;
      int        gnt_cycle;
      logic      want_valid;
      addr          = fab_addr_t'(take_bits(FAB_ADDR_W));
      wdata         = take_bits(DATA_W);
      be            = be_t'(take_bits(BE_W));
      gnt_cycle     = 0;
      enable_lint_i = v.enable[0];
      lint_req_i    = 1'b1;
      lint_wen_i    = v.stim[0];
      lint_addr_i   = addr;
      lint_wdata_i  = wdata;
      lint_be_i     = be;
      for (int cyc = 1; cyc <= v.hold && gnt_cycle == 0; cyc++) begin
         #2;
         if (fab_lint_req_o !== (v.enable[0] && cyc == 1)) begin
            report_mismatch($sformatf("fab_lint_req_o %b in request cycle %0d",
                                      fab_lint_req_o, cyc));
         end
         if (v.enable[0] && cyc == 1 && (fab_lint_addr_o !== addr ||
                                         fab_lint_wen_o !== v.stim[0] ||
                                         fab_lint_wdata_o !== wdata ||
                                         fab_lint_be_o !== be)) begin
            report_mismatch($sformatf("fab_lint_addr_o %h, expected %h, or fields differ",
                                      fab_lint_addr_o, addr));
         end
         want_valid = v.enable[0] ? (cyc == 2) : 1'b1;  // bypass always valid
         if (lint_rvalid_o !== want_valid) begin
            report_mismatch($sformatf("lint_rvalid_o %b, expected %b in cycle %0d",
                                      lint_rvalid_o, want_valid, cyc));
         end
         if (v.enable[0] && cyc == 2 && lint_rdata_o !== lint_read_data(addr)) begin
            report_mismatch($sformatf("lint_rdata_o %h, expected %h",
                                      lint_rdata_o, lint_read_data(addr)));
         end
         if (lint_gnt_o === 1'b1) begin
            gnt_cycle = cyc;
         end
         next_cycle();
      end
      lint_req_i = 1'b0;
      if (gnt_cycle != v.exp_val) begin
         report_mismatch($sformatf("lint grant in request cycle %0d, expected %0d",
                                   gnt_cycle, v.exp_val));
      end
      next_cycle();  // gap between requests
   endtask

   task automatic apply_tcdm(input tb_vector_t v);
      int                      port;
      logic                    wen;
      fab_addr_t               addr;
      data_t                   wdata;
      be_t                     be;
      soc_addr_t               soc_addr;
      logic                    granted;
      int                      rvalids;
      logic [N_TCDM_PORTS-1:0] want_req;
      port     = v.stim[1:0];
      wen      = v.stim[4];
      addr     = fab_addr_t'(take_bits(FAB_ADDR_W));
      wdata    = take_bits(DATA_W);
      be       = be_t'(take_bits(BE_W));
      soc_addr = {L2_WINDOW_HI, addr};
      granted  = 1'b0;
      rvalids  = 0;
      enable_tcdm_i          = v.enable;
      fab_tcdm_req_i[port]   = 1'b1;
      fab_tcdm_wen_i[port]   = wen;
      fab_tcdm_addr_i[port]  = addr;
      fab_tcdm_wdata_i[port] = wdata;
      fab_tcdm_be_i[port]    = be;
      for (int cyc = 1; cyc <= v.hold; cyc++) begin
         #2;
         want_req = '0;
         want_req[port] = v.exp_val[0] & ~granted;
         if (soc_tcdm_req_o !== want_req) begin
            report_mismatch($sformatf("soc_tcdm_req_o %b, expected %b", soc_tcdm_req_o, want_req));
         end
         if (fab_tcdm_gnt_o[port] !== v.exp_val[0]) begin
            report_mismatch($sformatf("fab_tcdm_gnt_o[%0d] %b", port, fab_tcdm_gnt_o[port]));
         end
         if (want_req[port] && (soc_tcdm_addr_o[port] !== soc_addr ||
                                soc_tcdm_wdata_o[port] !== wdata ||
                                soc_tcdm_be_o[port] !== be ||
                                soc_tcdm_wen_o[port] !== wen)) begin
            report_mismatch($sformatf("port %0d addr %h, expected %h, or fields differ",
                                      port, soc_tcdm_addr_o[port], soc_addr));
         end
         if (fab_tcdm_rvalid_o[port] === 1'b1) begin
            rvalids++;
            if (fab_tcdm_rdata_o[port] !== tcdm_read_data(soc_addr)) begin
               report_mismatch($sformatf("fab_tcdm_rdata_o[%0d] %h, expected %h", port,
                                         fab_tcdm_rdata_o[port], tcdm_read_data(soc_addr)));
            end
         end
         if (fab_tcdm_gnt_o[port] === 1'b1) begin
            granted = 1'b1;  // completes at the coming edge
         end
         next_cycle();
         if (granted) begin
            fab_tcdm_req_i = '0;
         end
      end
      fab_tcdm_req_i = '0;
      if (rvalids != int'(v.exp_val[1])) begin
         report_mismatch($sformatf("port %0d gave %0d read valids, expected %0d",
                                   port, rvalids, v.exp_val[1]));
      end
   endtask

   initial begin : main
      rst_n            = 1'b0;
      control_i        = '0;
      enable_events_i  = 1'b0;
      events_i         = '0;
      enable_lint_i    = 1'b0;
      lint_req_i       = 1'b0;
      lint_wen_i       = 1'b0;
      lint_addr_i      = '0;
      lint_wdata_i     = '0;
      lint_be_i        = '0;
      enable_tcdm_i    = '0;
      fab_tcdm_req_i   = '0;
      fab_tcdm_wen_i   = '0;
      fab_tcdm_addr_i  = '0;
      fab_tcdm_wdata_i = '0;
      fab_tcdm_be_i    = '0;
      repeat (RESET_CYCLES) @(posedge asic_clk_i);
      #1;
      rst_n = 1'b1;
      if (control_o !== '0 || event_o !== '0) begin
         report_mismatch($sformatf("control_o %h event_o %h after reset", control_o, event_o));
      end
      if (fab_lint_req_o !== 1'b0 || lint_gnt_o !== 1'b0) begin
         report_mismatch("lint request or grant high after reset");
      end
      next_cycle();
      for (int n = 0; n < N_VECTORS; n++) begin
         case (VECTORS[n].kind)
            VEC_CONTROL: apply_control(VECTORS[n]);
            VEC_EVENT:   apply_event(VECTORS[n]);
            VEC_LINT:    apply_lint(VECTORS[n]);
            default:     apply_tcdm(VECTORS[n]);
         endcase
      end
      $display("vectors applied: %0d, errors: %0d", N_VECTORS, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   initial begin : watchdog
      #(LIMIT_CYCLES * CLK_PERIOD);
      $display("timeout, vector table not finished after %0d cycles", LIMIT_CYCLES);
      $display("** FAIL **");
      $finish;
   end

endmodule

//--- hdl/efpga_bridge.sv
`timescale 1ns/1ps

module efpga_bridge (
   input  logic                                      asic_clk_i,
   input  logic                                      rst_n,
   // control word
   input  efpga_bridge_pkg::ctrl_word_t              control_i,
   output efpga_bridge_pkg::ctrl_word_t              control_o,
   // fabric events
   input  logic                                      enable_events_i,
   input  logic [efpga_bridge_pkg::N_EVENTS-1:0]     events_i,
   output logic [efpga_bridge_pkg::N_EVENTS-1:0]     event_o,
   // lint path
   input  logic                                      enable_lint_i,
   input  logic                                      lint_req_i,
   input  logic                                      lint_wen_i,
   input  efpga_bridge_pkg::fab_addr_t               lint_addr_i,
   input  efpga_bridge_pkg::data_t                   lint_wdata_i,
   input  efpga_bridge_pkg::be_t                     lint_be_i,
   output logic                                      lint_gnt_o,
   output logic                                      lint_rvalid_o,
   output efpga_bridge_pkg::data_t                   lint_rdata_o,
   output logic                                      fab_lint_req_o,
   output logic                                      fab_lint_wen_o,
   output efpga_bridge_pkg::fab_addr_t               fab_lint_addr_o,
   output efpga_bridge_pkg::data_t                   fab_lint_wdata_o,
   output efpga_bridge_pkg::be_t                     fab_lint_be_o,
   input  logic                                      fab_lint_gnt_i,
   input  logic                                      fab_lint_rvalid_i,
   input  efpga_bridge_pkg::data_t                   fab_lint_rdata_i,
   // TCDM ports
   input  logic [efpga_bridge_pkg::N_TCDM_PORTS-1:0] enable_tcdm_i,
   input  logic [efpga_bridge_pkg::N_TCDM_PORTS-1:0] fab_tcdm_req_i,
   input  logic [efpga_bridge_pkg::N_TCDM_PORTS-1:0] fab_tcdm_wen_i,
   input  efpga_bridge_pkg::fab_addr_t
          [efpga_bridge_pkg::N_TCDM_PORTS-1:0]       fab_tcdm_addr_i,
   input  efpga_bridge_pkg::data_t
          [efpga_bridge_pkg::N_TCDM_PORTS-1:0]       fab_tcdm_wdata_i,
   input  efpga_bridge_pkg::be_t
          [efpga_bridge_pkg::N_TCDM_PORTS-1:0]       fab_tcdm_be_i,
   output logic [efpga_bridge_pkg::N_TCDM_PORTS-1:0] fab_tcdm_gnt_o,
   output logic [efpga_bridge_pkg::N_TCDM_PORTS-1:0] fab_tcdm_rvalid_o,
   output efpga_bridge_pkg::data_t
          [efpga_bridge_pkg::N_TCDM_PORTS-1:0]       fab_tcdm_rdata_o,
   output logic [efpga_bridge_pkg::N_TCDM_PORTS-1:0] soc_tcdm_req_o,
   output logic [efpga_bridge_pkg::N_TCDM_PORTS-1:0] soc_tcdm_wen_o,
   output efpga_bridge_pkg::soc_addr_t
          [efpga_bridge_pkg::N_TCDM_PORTS-1:0]       soc_tcdm_addr_o,
   output efpga_bridge_pkg::data_t
          [efpga_bridge_pkg::N_TCDM_PORTS-1:0]       soc_tcdm_wdata_o,
   output efpga_bridge_pkg::be_t
          [efpga_bridge_pkg::N_TCDM_PORTS-1:0]       soc_tcdm_be_o,
   input  logic [efpga_bridge_pkg::N_TCDM_PORTS-1:0] soc_tcdm_gnt_i,
   input  logic [efpga_bridge_pkg::N_TCDM_PORTS-1:0] soc_tcdm_rvalid_i,
   input  efpga_bridge_pkg::data_t
          [efpga_bridge_pkg::N_TCDM_PORTS-1:0]       soc_tcdm_rdata_i
);

   control_word_filter u_control_filter (
      .asic_clk_i (asic_clk_i),
      .rst_n      (rst_n),
      .control_i  (control_i),
      .control_o  (control_o)
   );

   event_pulse_gen u_event_gen (
      .asic_clk_i (asic_clk_i),
      .rst_n      (rst_n),
      .enable_i   (enable_events_i),
      .events_i   (events_i),
      .event_o    (event_o)
   );

   lint_slave_gate u_lint_gate (
      .asic_clk_i        (asic_clk_i),
      .rst_n             (rst_n),
      .enable_i          (enable_lint_i),
      .lint_req_i        (lint_req_i),
      .lint_wen_i        (lint_wen_i),
      .lint_addr_i       (lint_addr_i),
      .lint_wdata_i      (lint_wdata_i),
      .lint_be_i         (lint_be_i),
      .lint_gnt_o        (lint_gnt_o),
      .lint_rvalid_o     (lint_rvalid_o),
      .lint_rdata_o      (lint_rdata_o),
      .fab_lint_req_o    (fab_lint_req_o),
      .fab_lint_wen_o    (fab_lint_wen_o),
      .fab_lint_addr_o   (fab_lint_addr_o),
      .fab_lint_wdata_o  (fab_lint_wdata_o),
      .fab_lint_be_o     (fab_lint_be_o),
      .fab_lint_gnt_i    (fab_lint_gnt_i),
      .fab_lint_rvalid_i (fab_lint_rvalid_i),
      .fab_lint_rdata_i  (fab_lint_rdata_i)
   );

   tcdm_port_gate u_tcdm_gate (
      .asic_clk_i        (asic_clk_i),
      .rst_n             (rst_n),
      .enable_i          (enable_tcdm_i),
      .fab_tcdm_req_i    (fab_tcdm_req_i),
      .fab_tcdm_wen_i    (fab_tcdm_wen_i),
      .fab_tcdm_addr_i   (fab_tcdm_addr_i),
      .fab_tcdm_wdata_i  (fab_tcdm_wdata_i),
      .fab_tcdm_be_i     (fab_tcdm_be_i),
      .fab_tcdm_gnt_o    (fab_tcdm_gnt_o),
      .fab_tcdm_rvalid_o (fab_tcdm_rvalid_o),
      .fab_tcdm_rdata_o  (fab_tcdm_rdata_o),
      .soc_tcdm_req_o    (soc_tcdm_req_o),
      .soc_tcdm_wen_o    (soc_tcdm_wen_o),
      .soc_tcdm_addr_o   (soc_tcdm_addr_o),
      .soc_tcdm_wdata_o  (soc_tcdm_wdata_o),
      .soc_tcdm_be_o     (soc_tcdm_be_o),
      .soc_tcdm_gnt_i    (soc_tcdm_gnt_i),
      .soc_tcdm_rvalid_i (soc_tcdm_rvalid_i),
      .soc_tcdm_rdata_i  (soc_tcdm_rdata_i)
   );

endmodule

//--- hdl/tcdm_port_gate.sv
`timescale 1ns/1ps

module tcdm_port_gate (
   input  logic                                          asic_clk_i,
   input  logic                                          rst_n,
   input  logic [efpga_bridge_pkg::N_TCDM_PORTS-1:0]     enable_i,
   // fabric TCDM masters
   input  logic [efpga_bridge_pkg::N_TCDM_PORTS-1:0]     fab_tcdm_req_i,
   input  logic [efpga_bridge_pkg::N_TCDM_PORTS-1:0]     fab_tcdm_wen_i,
   input  efpga_bridge_pkg::fab_addr_t
          [efpga_bridge_pkg::N_TCDM_PORTS-1:0]           fab_tcdm_addr_i,
   input  efpga_bridge_pkg::data_t
          [efpga_bridge_pkg::N_TCDM_PORTS-1:0]           fab_tcdm_wdata_i,
   input  efpga_bridge_pkg::be_t
          [efpga_bridge_pkg::N_TCDM_PORTS-1:0]           fab_tcdm_be_i,
   output logic [efpga_bridge_pkg::N_TCDM_PORTS-1:0]     fab_tcdm_gnt_o,
   output logic [efpga_bridge_pkg::N_TCDM_PORTS-1:0]     fab_tcdm_rvalid_o,
   output efpga_bridge_pkg::data_t
          [efpga_bridge_pkg::N_TCDM_PORTS-1:0]           fab_tcdm_rdata_o,
   // SoC memory side
   output logic [efpga_bridge_pkg::N_TCDM_PORTS-1:0]     soc_tcdm_req_o,
   output logic [efpga_bridge_pkg::N_TCDM_PORTS-1:0]     soc_tcdm_wen_o,
   output efpga_bridge_pkg::soc_addr_t
          [efpga_bridge_pkg::N_TCDM_PORTS-1:0]           soc_tcdm_addr_o,
   output efpga_bridge_pkg::data_t
          [efpga_bridge_pkg::N_TCDM_PORTS-1:0]           soc_tcdm_wdata_o,
   output efpga_bridge_pkg::be_t
          [efpga_bridge_pkg::N_TCDM_PORTS-1:0]           soc_tcdm_be_o,
   input  logic [efpga_bridge_pkg::N_TCDM_PORTS-1:0]     soc_tcdm_gnt_i,
   input  logic [efpga_bridge_pkg::N_TCDM_PORTS-1:0]     soc_tcdm_rvalid_i,
   input  efpga_bridge_pkg::data_t
          [efpga_bridge_pkg::N_TCDM_PORTS-1:0]           soc_tcdm_rdata_i
);
   import efpga_bridge_pkg::*;

   for (genvar p = 0; p < N_TCDM_PORTS; p++) begin : g_port
      tcdm_op_e op_q;  // operation of the last request on this port

      // request side, purely combinational
      assign soc_tcdm_req_o[p]   = fab_tcdm_req_i[p] & enable_i[p];
      assign soc_tcdm_wen_o[p]   = fab_tcdm_wen_i[p];
      assign soc_tcdm_addr_o[p]  = {L2_BASE_HI, fab_tcdm_addr_i[p]};  // into L2 window
      assign soc_tcdm_wdata_o[p] = fab_tcdm_wdata_i[p];
      assign soc_tcdm_be_o[p]    = fab_tcdm_be_i[p];
      assign fab_tcdm_gnt_o[p]   = soc_tcdm_gnt_i[p] & enable_i[p];

      always_ff @(posedge asic_clk_i or negedge rst_n) begin
         if (!rst_n) begin
            op_q <= TCDM_READ;
         end else if (soc_tcdm_req_o[p]) begin
            op_q <= tcdm_op_e'(fab_tcdm_wen_i[p]);
         end
      end

      // write responses stay on the SoC side
      assign fab_tcdm_rvalid_o[p] = soc_tcdm_rvalid_i[p] & (op_q == TCDM_READ);
      assign fab_tcdm_rdata_o[p]  = soc_tcdm_rdata_i[p];
   end

endmodule

//--- hdl/lint_slave_gate.sv
`timescale 1ns/1ps

module lint_slave_gate (
   input  logic                        asic_clk_i,
   input  logic                        rst_n,
   input  logic                        enable_i,
   // SoC lint master side
   input  logic                        lint_req_i,
   input  logic                        lint_wen_i,
   input  efpga_bridge_pkg::fab_addr_t lint_addr_i,
   input  efpga_bridge_pkg::data_t     lint_wdata_i,
   input  efpga_bridge_pkg::be_t       lint_be_i,
   output logic                        lint_gnt_o,
   output logic                        lint_rvalid_o,
   output efpga_bridge_pkg::data_t     lint_rdata_o,
   // fabric lint slave side
   output logic                        fab_lint_req_o,
   output logic                        fab_lint_wen_o,
   output efpga_bridge_pkg::fab_addr_t fab_lint_addr_o,
   output efpga_bridge_pkg::data_t     fab_lint_wdata_o,
   output efpga_bridge_pkg::be_t       fab_lint_be_o,
   input  logic                        fab_lint_gnt_i,
   input  logic                        fab_lint_rvalid_i,
   input  efpga_bridge_pkg::data_t     fab_lint_rdata_i
);
   import efpga_bridge_pkg::*;

   lint_phase_e state_q;
   lint_phase_e state_d;
   lint_phase_e phase;  // phase of the current cycle
   lint_cnt_t   cnt_q;
   lint_cnt_t   cnt_d;

   // a new request is in its issue cycle before the register sees it
   always_comb begin
      phase = state_q;
      if (state_q == LINT_IDLE && lint_req_i) begin
         phase = LINT_ISSUE;
      end
   end

   always_comb begin
      state_d = state_q;
      cnt_d   = cnt_q;
      if (!enable_i || !lint_req_i) begin
         state_d = LINT_IDLE;  // request dropped or bypassed
         cnt_d   = '0;
      end else begin
         case (phase)
            LINT_ISSUE: begin
               cnt_d   = lint_cnt_t'(1);
               state_d = (cnt_d == lint_cnt_t'(GRANT_DELAY)) ? LINT_GRANT : LINT_HOLD;
            end
            LINT_HOLD: begin
               cnt_d = cnt_q + 1'b1;
               if (cnt_d == lint_cnt_t'(GRANT_DELAY)) begin
                  state_d = LINT_GRANT;
               end
            end
            LINT_GRANT: begin
               if (lint_gnt_o) begin
                  state_d = LINT_IDLE;  // transfer done, master drops req
                  cnt_d   = '0;
               end
            end
            default: begin
               state_d = LINT_IDLE;
               cnt_d   = '0;
            end
         endcase
      end
   end

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= LINT_IDLE;
         cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         cnt_q   <= cnt_d;
      end
   end

   // bypass answers on its own when disabled
   assign lint_gnt_o     = enable_i ? (lint_req_i & (phase == LINT_GRANT) & fab_lint_gnt_i)
                                    : lint_req_i;
   assign lint_rvalid_o  = enable_i ? fab_lint_rvalid_i : 1'b1;
   assign lint_rdata_o   = fab_lint_rdata_i;
   assign fab_lint_req_o = enable_i & (phase == LINT_ISSUE);  // once per request

   assign fab_lint_wen_o   = lint_wen_i;
   assign fab_lint_addr_o  = lint_addr_i;
   assign fab_lint_wdata_o = lint_wdata_i;
   assign fab_lint_be_o    = lint_be_i;

endmodule

//--- hdl/event_pulse_gen.sv
`timescale 1ns/1ps

module event_pulse_gen (
   input  logic                                  asic_clk_i,
   input  logic                                  rst_n,
   input  logic                                  enable_i,
   input  logic [efpga_bridge_pkg::N_EVENTS-1:0] events_i,
   output logic [efpga_bridge_pkg::N_EVENTS-1:0] event_o
);
   import efpga_bridge_pkg::*;

   logic [N_EVENTS-1:0] gated;
   logic [N_EVENTS-1:0] level_q;  // fabric levels, one stage in
   logic [N_EVENTS-1:0] prev_q;   // level one cycle earlier

   assign gated = events_i & {N_EVENTS{enable_i}};

   // stands in for the crossing stage of the fabric clock
   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         level_q <= '0;
      end else begin
         level_q <= gated;
      end
   end

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         prev_q <= '0;
      end else begin
         prev_q <= level_q;
      end
   end

   // rising edge only, so a held level gives a single pulse
   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         event_o <= '0;
      end else begin
         event_o <= level_q & ~prev_q;
      end
   end

endmodule

//--- hdl/control_word_filter.sv
`timescale 1ns/1ps

module control_word_filter (
   input  logic                         asic_clk_i,
   input  logic                         rst_n,
   input  efpga_bridge_pkg::ctrl_word_t control_i,
   output efpga_bridge_pkg::ctrl_word_t control_o
);
   import efpga_bridge_pkg::*;

   ctrl_word_t hist_q [STABLE_SAMPLES-1];  // [0] is the newest sample
   logic       accept_q;
   logic       all_equal;

   // all stored samples must match what is on the input now
   always_comb begin
      all_equal = 1'b1;
      for (int i = 0; i < STABLE_SAMPLES-1; i++) begin
         if (hist_q[i] != control_i) begin
            all_equal = 1'b0;
         end
      end
   end

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < STABLE_SAMPLES-1; i++) begin
            hist_q[i] <= '0;
         end
         accept_q <= 1'b0;
      end else begin
         hist_q[0] <= control_i;
         for (int i = 1; i < STABLE_SAMPLES-1; i++) begin
            hist_q[i] <= hist_q[i-1];  // shift history
         end
         accept_q <= all_equal;
      end
   end

   // newest sample is the one that was just proven stable
   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         control_o <= '0;
      end else if (accept_q) begin
         control_o <= hist_q[0];
      end
   end

endmodule

//--- hdl/efpga_bridge_pkg.sv
package efpga_bridge_pkg;

   // widths
   localparam int CTRL_W       = 32;
   localparam int N_EVENTS     = 16;
   localparam int N_TCDM_PORTS = 4;
   localparam int FAB_ADDR_W   = 20;
   localparam int SOC_ADDR_W   = 32;
   localparam int DATA_W       = 32;
   localparam int BE_W         = 4;

   // upper address bits of the L2 window
   localparam logic [SOC_ADDR_W-FAB_ADDR_W-1:0] L2_BASE_HI = 12'h1C0;

   localparam int GRANT_DELAY    = 4;  // request cycles before lint grant
   localparam int STABLE_SAMPLES = 3;  // equal samples before control load

   typedef logic [CTRL_W-1:0]     ctrl_word_t;
   typedef logic [FAB_ADDR_W-1:0] fab_addr_t;
   typedef logic [SOC_ADDR_W-1:0] soc_addr_t;
   typedef logic [DATA_W-1:0]     data_t;
   typedef logic [BE_W-1:0]       be_t;

   // counts completed lint request cycles
   typedef logic [$clog2(GRANT_DELAY+1)-1:0] lint_cnt_t;

   // same encoding as wen
   typedef enum logic {
      TCDM_WRITE = 1'b0,
      TCDM_READ  = 1'b1
   } tcdm_op_e;

   typedef enum logic [1:0] {
      LINT_IDLE  = 2'd0,  // no request
      LINT_ISSUE = 2'd1,  // first request cycle, fabric request out
      LINT_HOLD  = 2'd2,  // counting towards GRANT_DELAY
      LINT_GRANT = 2'd3   // waiting for fabric grant
   } lint_phase_e;

endpackage
